//--- Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/branch_predecode.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module branch_predecode import core_pkg::*; (
	input  logic [`INST_W-1:0] inst,
	output br_kind_e           kind,
	output logic [`XLEN-1:0]   imm,
	output logic               backward
);

	// major opcodes that matter to fetch
	typedef enum logic [6:0] {
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111
	} opcode_e;

	opcode_e          opcode;
	logic [2:0]       funct3;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_j;

	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];

	// ****************************************
	// classify
	// ****************************************
	always_comb begin
		kind = br_none;
		case (opcode)
			op_branch: begin
				// beq bne blt bge bltu bgeu, 010/011 are not branches
				case (funct3)
					3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111: kind = br_cond;
					default: kind = br_none;
				endcase
			end
			op_jal: kind = br_jal;
			default: kind = br_none;
		endcase
	end

	// ****************************************
	// immediates
	// ****************************************
	// B type, 13 bit offset scattered over the word
	assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
		inst[11:8], 1'b0};
	// J type, 21 bit offset
	assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
		inst[30:21], 1'b0};

	// only meaningful when kind is not br_none
	assign imm = (kind == br_jal) ? imm_j : imm_b;

	// sign bit of the offset, negative means loop back
	assign backward = inst[31];

endmodule

//--- hw/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// ****************************************
// datapath widths
// ****************************************
`define XLEN 64
`define INST_W 32

// boot address, also the base of the unified memory
`define RESET_PC 64'h0000_0000_8000_0000

// 64-bit words in the unified memory
`define MEM_WORDS 1024

// denied fetch cycles in a row before fetch is forced through
`define STARVE_LIMIT 4

`endif

//--- hw/core_pkg.sv
package core_pkg;

	// ****************************************
	// fetch side
	// ****************************************

	// predecode class of the fetched instruction
	typedef enum logic [1:0] {
		br_none,
		br_cond,
		br_jal
	} br_kind_e;

	// ****************************************
	// data side
	// ****************************************

	// load/store width
	typedef enum logic {
		size_word,
		size_double
	} access_size_e;

	// who drives the shared memory this cycle
	typedef enum logic [1:0] {
		own_none,
		own_fetch,
		own_data
	} arb_owner_e;

endpackage

//--- hw/data_port.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module data_port import core_pkg::*; (
	input  logic              d_req,
	input  logic              d_we,
	input  access_size_e      d_size,
	input  logic [`XLEN-1:0]  d_addr,
	input  logic [`XLEN-1:0]  d_wdata,
	output logic [`XLEN-1:0]  d_rdata,
	output logic              d_done,
	data_bus_if.requester     dbus
);

	logic [31:0] load_half;

	// ****************************************
	// request side
	// ****************************************
	assign dbus.req  = d_req;
	assign dbus.we   = d_we;
	// memory is addressed in whole double words
	assign dbus.addr = {d_addr[`XLEN-1:3], 3'b000};

	// lane steering and strobes
	always_comb begin
		case (d_size)
			size_word: begin
				// copy into both halves, strobes pick the lane
				dbus.wdata = {2{d_wdata[31:0]}};
				dbus.wstrb = d_addr[2] ? 8'hf0 : 8'h0f;
			end
			default: begin
				dbus.wdata = d_wdata;
				dbus.wstrb = 8'hff;
			end
		endcase
		// loads touch no byte
		if (!d_we)
			dbus.wstrb = 8'h00;
	end

	// ****************************************
	// response side
	// ****************************************
	assign load_half = d_addr[2] ? dbus.rdata[63:32] : dbus.rdata[31:0];

	always_comb begin
		case (d_size)
			// sign extend like lw
			size_word: d_rdata = {{(`XLEN-32){load_half[31]}}, load_half};
			default:   d_rdata = dbus.rdata;
		endcase
	end

	// same cycle completion when granted
	assign d_done = d_req & dbus.gnt;

endmodule

//--- hw/fetch_unit.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module fetch_unit import core_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	input  logic                ready_if_id,
	input  logic                pc_update,
	input  logic [`XLEN-1:0]    dnpc,
	output logic                valid_if_id,
	output logic [`XLEN-1:0]    pc,
	output logic [`INST_W-1:0]  inst,
	output logic                branch_flush,
	fetch_bus_if.requester      fbus
);

	br_kind_e          kind;
	logic [`XLEN-1:0]  imm;
	logic              backward;
	logic              accept;
	logic              predict_taken;
	logic [`XLEN-1:0]  pc_next;

	// ****************************************
	// memory request
	// ****************************************
	// no request while decode holds us
	assign fbus.req  = ready_if_id;
	assign fbus.addr = {pc[`XLEN-1:3], 3'b000};

	// pick the 32-bit half by pc[2]
	assign inst = pc[2] ? fbus.rdata[`XLEN-1:`INST_W] : fbus.rdata[`INST_W-1:0];

	// instruction taken by decode this cycle
	assign accept = ready_if_id & fbus.gnt;

	// redirect kills the fetched word
	assign valid_if_id  = accept & ~pc_update;
	assign branch_flush = accept & pc_update;

	branch_predecode u_predecode (
		.inst     (inst),
		.kind     (kind),
		.imm      (imm),
		.backward (backward)
	);

	// static rule, backward cond or backward jal
	assign predict_taken = backward & ((kind == br_cond) | (kind == br_jal));

	// ****************************************
	// next pc
	// ****************************************
	always_comb begin
		if (!accept) begin
			// stalled by decode or by the arbiter
			pc_next = pc;
		end else if (pc_update) begin
			pc_next = dnpc;
		end else if (predict_taken) begin
			pc_next = pc + imm;
		end else begin
			pc_next = pc + `XLEN'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

//--- hw/ifu_mem_top.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module ifu_mem_top import core_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	// decode side
	input  logic                ready_if_id,
	input  logic                pc_update,
	input  logic [`XLEN-1:0]    dnpc,
	output logic                valid_if_id,
	output logic [`XLEN-1:0]    pc,
	output logic [`INST_W-1:0]  inst,
	output logic                branch_flush,
	// load/store side
	input  logic                d_req,
	input  logic                d_we,
	input  access_size_e        d_size,
	input  logic [`XLEN-1:0]    d_addr,
	input  logic [`XLEN-1:0]    d_wdata,
	output logic [`XLEN-1:0]    d_rdata,
	output logic                d_done
);

	// shared memory port
	logic [`XLEN-1:0] mem_addr;
	logic             mem_we;
	logic [`XLEN-1:0] mem_wdata;
	logic [7:0]       mem_wstrb;
	logic [`XLEN-1:0] mem_rdata;

	fetch_bus_if fbus ();
	data_bus_if  dbus ();

	// ****************************************
	// requesters
	// ****************************************
	fetch_unit u_fetch (
		.clk          (clk),
		.reset        (reset),
		.ready_if_id  (ready_if_id),
		.pc_update    (pc_update),
		.dnpc         (dnpc),
		.valid_if_id  (valid_if_id),
		.pc           (pc),
		.inst         (inst),
		.branch_flush (branch_flush),
		.fbus         (fbus.requester)
	);

	data_port u_data (
		.d_req   (d_req),
		.d_we    (d_we),
		.d_size  (d_size),
		.d_addr  (d_addr),
		.d_wdata (d_wdata),
		.d_rdata (d_rdata),
		.d_done  (d_done),
		.dbus    (dbus.requester)
	);

	// ****************************************
	// arbiter and memory
	// ****************************************
	mem_arbiter u_arb (
		.clk       (clk),
		.reset     (reset),
		.fbus      (fbus.arbiter),
		.dbus      (dbus.arbiter),
		.mem_addr  (mem_addr),
		.mem_we    (mem_we),
		.mem_wdata (mem_wdata),
		.mem_wstrb (mem_wstrb),
		.mem_rdata (mem_rdata)
	);

	unified_mem u_mem (
		.clk   (clk),
		.addr  (mem_addr),
		.we    (mem_we),
		.wdata (mem_wdata),
		.wstrb (mem_wstrb),
		.rdata (mem_rdata)
	);

endmodule

//--- hw/mem_arbiter.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module mem_arbiter import core_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	fetch_bus_if.arbiter      fbus,
	data_bus_if.arbiter       dbus,
	output logic [`XLEN-1:0]  mem_addr,
	output logic              mem_we,
	output logic [`XLEN-1:0]  mem_wdata,
	output logic [7:0]        mem_wstrb,
	input  logic [`XLEN-1:0]  mem_rdata
);

	localparam int CNT_W = $clog2(`STARVE_LIMIT + 1);

	arb_owner_e        owner;
	logic [CNT_W-1:0]  starve_cnt;
	logic              starved;

	// ****************************************
	// owner select
	// ****************************************
	// fetch denied long enough
	assign starved = (starve_cnt == CNT_W'(`STARVE_LIMIT));

	always_comb begin
		if (fbus.req && (starved || !dbus.req))
			owner = own_fetch;
		else if (dbus.req)
			owner = own_data;
		else
			owner = own_none;
	end

	assign fbus.gnt = (owner == own_fetch);
	assign dbus.gnt = (owner == own_data);

	// ****************************************
	// starvation counter
	// ****************************************
	always_ff @(posedge clk) begin
		if (reset) begin
			starve_cnt <= '0;
		end else if (!fbus.req || owner == own_fetch) begin
			starve_cnt <= '0;
		end else begin
			// requesting and lost to data
			starve_cnt <= starve_cnt + CNT_W'(1);
		end
	end

	// ****************************************
	// memory drive
	// ****************************************
	always_comb begin
		mem_addr  = fbus.addr;
		mem_we    = 1'b0;
		mem_wstrb = 8'h00;
		case (owner)
			own_data: begin
				mem_addr  = dbus.addr;
				mem_we    = dbus.we;
				mem_wstrb = dbus.wstrb;
			end
			default: ;
		endcase
	end

	assign mem_wdata = dbus.wdata;

	// both sides see the read word and gnt says who owns it
	assign fbus.rdata = mem_rdata;
	assign dbus.rdata = mem_rdata;

endmodule

//--- hw/mem_if.sv
`timescale 1ns/100ps
`include "core_defs.svh"

// ****************************************
// fetch request path
// ****************************************
// served when req and gnt are both high, rdata valid same cycle
interface fetch_bus_if;
	logic              req;
	// double word aligned
	logic [`XLEN-1:0]  addr;
	logic              gnt;
	logic [`XLEN-1:0]  rdata;

	modport requester (
		output req,
		output addr,
		input  gnt,
		input  rdata
	);

	modport arbiter (
		input  req,
		input  addr,
		output gnt,
		output rdata
	);
endinterface

// ****************************************
// load/store path
// ****************************************
// same single cycle rule as the fetch path
interface data_bus_if;
	logic              req;
	logic              we;
	logic [`XLEN-1:0]  addr;
	logic [`XLEN-1:0]  wdata;
	// one bit per byte lane
	logic [7:0]        wstrb;
	logic              gnt;
	logic [`XLEN-1:0]  rdata;

	modport requester (
		output req,
		output we,
		output addr,
		output wdata,
		output wstrb,
		input  gnt,
		input  rdata
	);

	modport arbiter (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		input  wstrb,
		output gnt,
		output rdata
	);
endinterface

//--- hw/unified_mem.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module unified_mem (
	input  logic              clk,
	input  logic [`XLEN-1:0]  addr,
	input  logic              we,
	input  logic [`XLEN-1:0]  wdata,
	input  logic [7:0]        wstrb,
	output logic [`XLEN-1:0]  rdata
);

	localparam int IDX_W = $clog2(`MEM_WORDS);

	logic [`XLEN-1:0]  mem [`MEM_WORDS];
	logic [`XLEN-1:0]  offset;
	logic [IDX_W-1:0]  idx;

	// ****************************************
	// address map
	// ****************************************
	// relative to boot address, wraps modulo depth
	assign offset = addr - `RESET_PC;
	assign idx    = offset[IDX_W+2:3];

	// combinational read port
	assign rdata = mem[idx];

	// byte lanes written at the edge
	always_ff @(posedge clk) begin
		if (we) begin
			for (int i = 0; i < 8; i++) begin
				if (wstrb[i])
					mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
			end
		end
	end

endmodule

//--- tb/tb_top.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module tb_top import core_pkg::*; ();

	logic                clk;
	logic                reset;
	logic                ready_if_id;
	logic                pc_update;
	logic [`XLEN-1:0]    dnpc;
	logic                valid_if_id;
	logic [`XLEN-1:0]    pc;
	logic [`INST_W-1:0]  inst;
	logic                branch_flush;
	logic                d_req;
	logic                d_we;
	access_size_e        d_size;
	logic [`XLEN-1:0]    d_addr;
	logic [`XLEN-1:0]    d_wdata;
	logic [`XLEN-1:0]    d_rdata;
	logic                d_done;

	// reference model state
	logic [`XLEN-1:0]  model_mem [`MEM_WORDS];
	logic [`XLEN-1:0]  model_pc;
	int                starve_m;
	int                gap;
	logic              checking;
	int                errors;
	int                timeouts;

	ifu_mem_top dut (
		.clk          (clk),
		.reset        (reset),
		.ready_if_id  (ready_if_id),
		.pc_update    (pc_update),
		.dnpc         (dnpc),
		.valid_if_id  (valid_if_id),
		.pc           (pc),
		.inst         (inst),
		.branch_flush (branch_flush),
		.d_req        (d_req),
		.d_we         (d_we),
		.d_size       (d_size),
		.d_addr       (d_addr),
		.d_wdata      (d_wdata),
		.d_rdata      (d_rdata),
		.d_done       (d_done)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// ****************************************
	// model helpers
	// ****************************************
	// word index relative to base and wrapped
	function automatic int widx(logic [63:0] a);
		logic [63:0] off;
		off = a - `RESET_PC;
		return int'((off >> 3) % `MEM_WORDS);
	endfunction

	// static rule straight from the ISA encoding
	function automatic logic [63:0] predict_next(logic [63:0] cur, logic [31:0] w);
		logic [63:0] off_b;
		logic [63:0] off_j;
		logic        cond;
		off_b = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		off_j = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		// funct3 010 and 011 are not branches
		cond = (w[6:0] == 7'b1100011) && (w[14:13] != 2'b01);
		if (w[31] && cond)
			return cur + off_b;
		if (w[31] && w[6:0] == 7'b1101111)
			return cur + off_j;
		return cur + 64'd4;
	endfunction

	// random program word with branches and jal of either sign
	function automatic logic [31:0] make_inst();
		logic [31:0] r;
		logic [63:0] off;
		r = $urandom;
		off = 64'(($urandom % 64 + 1) * 4);
		if ($urandom % 2 == 0)
			off = -off;
		case ($urandom % 8)
			0, 1: return {off[12], off[10:5], r[24:12], off[4:1], off[11], 7'b1100011};
			2:    return {off[20], off[10:1], off[11], off[19:12], r[11:7], 7'b1101111};
			3:    return r;
			default: return {r[31:7], 7'b0010011};
		endcase
	endfunction

	function automatic logic [63:0] rand_pc();
		return `RESET_PC + 64'(($urandom % (`MEM_WORDS * 2)) * 4);
	endfunction

	function automatic logic [63:0] rand_addr(access_size_e size);
		logic [63:0] a;
		a = `RESET_PC + 64'(($urandom % `MEM_WORDS) * 8);
		if (size == size_word)
			a = a + 64'(($urandom % 2) * 4);
		return a;
	endfunction

	// ****************************************
	// checks and end of run
	// ****************************************
	task automatic check_bit(string name, logic exp, logic got);
		assert (got === exp) else begin
			errors++;
			$display("ERROR t=%0t %s expected %0b actual %0b", $time, name, exp, got);
		end
	endtask

	task automatic check_word(string name, logic [63:0] exp, logic [63:0] got);
		assert (got === exp) else begin
			errors++;
			$display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, got);
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	endtask

	task automatic report_timeout(string what);
		$display("timeout at t=%0t: %s never completed", $time, what);
		timeouts++;
	endtask

	// ****************************************
	// reference model sampled mid cycle
	// ****************************************
	always @(negedge clk) begin : monitor
		logic        exp_fetch;
		logic [31:0] exp_inst;
		logic [31:0] h;
		int          i;
		if (checking) begin
			// data wins unless fetch was denied long enough
			exp_fetch = ready_if_id && (!d_req || starve_m == `STARVE_LIMIT);
			i = widx(model_pc);
			exp_inst = model_pc[2] ? model_mem[i][63:32] : model_mem[i][31:0];
			check_word("pc", model_pc, pc);
			check_bit("valid_if_id", exp_fetch && !pc_update, valid_if_id);
			check_bit("branch_flush", exp_fetch && pc_update, branch_flush);
			check_bit("d_done", d_req && !exp_fetch, d_done);
			if (valid_if_id)
				check_word("inst", 64'(exp_inst), 64'(inst));
			if (d_req && !exp_fetch) begin
				i = widx(d_addr);
				if (d_we) begin
					// commits at the coming edge
					if (d_size == size_double)
						model_mem[i] = d_wdata;
					else if (d_addr[2])
						model_mem[i][63:32] = d_wdata[31:0];
					else
						model_mem[i][31:0] = d_wdata[31:0];
				end else begin
					h = d_addr[2] ? model_mem[i][63:32] : model_mem[i][31:0];
					if (d_size == size_double)
						check_word("d_rdata", model_mem[i], d_rdata);
					else
						check_word("d_rdata", {{32{h[31]}}, h}, d_rdata);
				end
			end
			// window seen from the outputs
			if (ready_if_id && d_req && !(valid_if_id || branch_flush))
				gap++;
			else
				gap = 0;
			assert (gap <= `STARVE_LIMIT) else begin
				errors++;
				$display("fetch got no memory slot for %0d cycles in a row", gap);
			end
			if (exp_fetch)
				model_pc = pc_update ? dnpc : predict_next(model_pc, exp_inst);
			if (ready_if_id && !exp_fetch)
				starve_m++;
			else
				starve_m = 0;
		end
	end

	// ****************************************
	// stimulus
	// ****************************************
	task automatic store_double(logic [63:0] addr, logic [63:0] data);
		int waited;
		@(posedge clk);
		d_req   <= 1'b1;
		d_we    <= 1'b1;
		d_size  <= size_double;
		d_addr  <= addr;
		d_wdata <= data;
		@(negedge clk);
		waited = 0;
		while (!d_done && timeouts == 0) begin
			waited++;
			if (waited > 16)
				report_timeout("program store");
			else
				@(negedge clk);
		end
	endtask

	task automatic drive_data(logic we, access_size_e size, logic [63:0] addr);
		d_req   <= 1'b1;
		d_we    <= we;
		d_size  <= size;
		d_addr  <= addr;
		d_wdata <= {$urandom, $urandom};
	endtask

	// busy keeps d_req and ready_if_id high and sends no redirects
	task automatic run_cycles(int n, bit busy);
		bit           d_pend;
		bit           u_pend;
		bit           chk_pend;
		logic [63:0]  chk_addr;
		logic         we;
		access_size_e size;
		logic [63:0]  addr;
		int           d_wait;
		int           u_wait;
		int           c;
		d_pend = 1'b0;
		u_pend = 1'b0;
		chk_pend = 1'b0;
		chk_addr = `RESET_PC;
		d_wait = 0;
		u_wait = 0;
		c = 0;
		while ((c < n || d_pend || u_pend) && timeouts == 0) begin
			@(posedge clk);
			if (!d_pend && c < n && (busy || $urandom % 3 == 0)) begin
				if (chk_pend) begin
					// read back the whole double after a word store
					drive_data(1'b0, size_double, chk_addr);
					chk_pend = 1'b0;
				end else begin
					we = ($urandom % 2) == 0;
					size = access_size_e'($urandom % 2);
					addr = rand_addr(size);
					drive_data(we, size, addr);
					chk_pend = we && size == size_word;
					chk_addr = {addr[63:3], 3'b000};
				end
				d_pend = 1'b1;
				d_wait = 0;
			end else if (!d_pend) begin
				d_req <= 1'b0;
			end
			if (!u_pend && !busy && c < n && $urandom % 12 == 0) begin
				pc_update <= 1'b1;
				dnpc <= rand_pc();
				u_pend = 1'b1;
				u_wait = 0;
			end else if (!u_pend) begin
				pc_update <= 1'b0;
			end
			ready_if_id <= busy || ($urandom % 6 != 0);
			@(negedge clk);
			if (d_pend && d_done) begin
				d_pend = 1'b0;
			end else if (d_pend) begin
				d_wait++;
				if (d_wait > 16)
					report_timeout("data access");
			end
			if (u_pend && branch_flush) begin
				u_pend = 1'b0;
			end else if (u_pend) begin
				u_wait++;
				if (u_wait > 64)
					report_timeout("redirect");
			end
			c++;
		end
		@(posedge clk);
		d_req <= 1'b0;
		pc_update <= 1'b0;
	endtask

	initial begin
		void'($urandom(32'h613c_07b4));
		clk = 1'b0;
		reset = 1'b1;
		ready_if_id = 1'b0;
		pc_update = 1'b0;
		dnpc = `RESET_PC;
		d_req = 1'b0;
		d_we = 1'b0;
		d_size = size_word;
		d_addr = `RESET_PC;
		d_wdata = '0;
		model_pc = `RESET_PC;
		starve_m = 0;
		gap = 0;
		checking = 1'b0;
		errors = 0;
		timeouts = 0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		checking = 1'b1;
		// program load with fetch held off
		for (int w = 0; w < `MEM_WORDS && timeouts == 0; w++)
			store_double(`RESET_PC + 64'(w * 8), {make_inst(), make_inst()});
		// mixed traffic then saturated data side then mixed again
		if (timeouts == 0)
			run_cycles(3000, 1'b0);
		if (timeouts == 0)
			run_cycles(400, 1'b1);
		if (timeouts == 0)
			run_cycles(1000, 1'b0);
		finish_run();
	end

endmodule

//--- vlog.f
+incdir+hw
hw/core_pkg.sv
hw/mem_if.sv
hw/branch_predecode.sv
hw/fetch_unit.sv
hw/data_port.sv
hw/mem_arbiter.sv
hw/unified_mem.sv
hw/ifu_mem_top.sv
tb/tb_top.sv
